// ==== python_ctrl_top.f ====
common/sensor_pkg.sv
common/spi_pkg.sv
common/spi_req_if.sv
sensor_power/sensor_pwr_mng.sv
python_spi/python_spi.sv
logic/spi_cmd.sv
logic/python_ctrl_top.sv
verification/python_spi_model.sv
verification/tb_python_ctrl_top.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_python_ctrl_top
FILELIST  := python_ctrl_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: compile
	./$(BIN) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_python_ctrl_top.sv ====
module tb_python_ctrl_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW         = spi_pkg::ADDR_W;
    localparam int DW         = spi_pkg::DATA_W;
    localparam int SD         = sensor_pkg::STEP_DELAY;
    localparam int CLK_PERIOD = 10;
    localparam int FRAME_CYC  = spi_pkg::FRAME_W * spi_pkg::SCK_DIV + 4;
    localparam int PWRUP_CYC  = 5 * SD + 300 + spi_pkg::INIT_LEN * FRAME_CYC;
    localparam int WORST_CYC  = PWRUP_CYC + 40 * FRAME_CYC;

    logic          clk72;
    logic          mipi_reset_n;
    logic          power_enable;
    logic          sensor_pgood;
    logic [AW-1:0] host_addr;
    logic          host_we;
    logic [DW-1:0] host_wdata;
    logic          host_valid;
    logic          host_ready;
    logic [DW-1:0] host_rdata;
    logic          host_rvalid;
    logic          init_done;
    logic          sensor_pwr_en_vdd18;
    logic          sensor_pwr_en_vdd33;
    logic          sensor_pwr_en_pix;
    logic          python_reset_n;
    logic          python_clk_pll;
    logic          python_ss_n;
    logic          python_sck;
    logic          python_mosi;
    logic          python_miso;

    // shadow of the sensor registers
    logic [DW-1:0] shadow [0:(1 << AW) - 1];
    logic [DW-1:0] exp_q [$];
    logic [AW-1:0] known_q [$];
    logic [DW-1:0] exp_v;

    // rise and fall cycle of vdd18 vdd33 pix pgood clk rst init_done
    logic [6:0] mon;
    logic [6:0] mon_q;
    int         rise_t [0:6];
    int         fall_t [0:6];
    int         cyc;

    int errors;
    int checks;
    int tests_run;
    int reads_issued;
    int rvalid_cnt;
    int frames;
    int bp_errors;
    int sck_edges;

    python_ctrl_top i_dut (.*);

    python_spi_model u_model (
        .ss_n (python_ss_n),
        .sck  (python_sck),
        .mosi (python_mosi),
        .miso (python_miso)
    );

    initial begin
        clk72 = 1'b0;
    end

    always #5 clk72 = ~clk72;

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic [DW-1:0] ref_read(input logic [AW-1:0] addr);
        return shadow[addr];
    endfunction

    task automatic load_init_shadow();
        for (int i = 0; i < spi_pkg::INIT_LEN; i++) begin
            shadow[spi_pkg::INIT_ADDR[i]] = spi_pkg::INIT_DATA[i];
        end
    endtask

    // ----------------------------------------
    // monitors and checker
    // ----------------------------------------

    assign mon = {init_done, python_reset_n, python_clk_pll, sensor_pgood,
                  sensor_pwr_en_pix, sensor_pwr_en_vdd33, sensor_pwr_en_vdd18};

    always @(posedge clk72) begin
        cyc = cyc + 1;
        for (int i = 0; i < 7; i++) begin
            if (mon[i] === 1'b1 && mon_q[i] !== 1'b1) begin
                rise_t[i] = cyc;
            end else if (mon[i] === 1'b0 && mon_q[i] === 1'b1) begin
                fall_t[i] = cyc;
            end
        end
        mon_q = mon;
    end

    // read responses against the reference in issue order
    always @(negedge clk72) begin
        if (host_rvalid === 1'b1) begin
            rvalid_cnt = rvalid_cnt + 1;
            checks     = checks + 1;
            assert (exp_q.size() != 0) else begin
                $display("read response arrived with no read outstanding");
                errors = errors + 1;
            end
            if (exp_q.size() != 0) begin
                exp_v  = exp_q.pop_front();
                checks = checks + 1;
                assert (host_rdata === exp_v) else begin
                    $display("ERROR host_rdata exp=%h got=%h", exp_v, host_rdata);
                    errors = errors + 1;
                end
            end
        end
    end

    // host must be held off before init and during a frame
    always @(negedge clk72) begin
        if (mipi_reset_n === 1'b1 && host_ready === 1'b1) begin
            checks = checks + 1;
            assert (init_done === 1'b1 && python_ss_n === 1'b1) else begin
                $display("host_ready was high before init_done or during a frame");
                errors    = errors + 1;
                bp_errors = bp_errors + 1;
            end
        end
    end

    always @(negedge python_ss_n) begin
        sck_edges = 0;
    end

    always @(posedge python_sck) begin
        sck_edges = sck_edges + 1;
    end

    always @(posedge python_ss_n) begin
        if (mipi_reset_n === 1'b1) begin
            frames = frames + 1;
            checks = checks + 1;
            assert (sck_edges == spi_pkg::FRAME_W) else begin
                $display("ss_n was low for %0d SCK rising edges instead of %0d",
                         sck_edges, spi_pkg::FRAME_W);
                errors    = errors + 1;
                bp_errors = bp_errors + 1;
            end
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------

    // sensor reports pgood some time after the pixel rail
    initial begin
        sensor_pgood = 1'b0;
        forever begin
            wait (sensor_pwr_en_pix === 1'b1);
            repeat ($urandom_range(300, 50)) @(negedge clk72);
            sensor_pgood = 1'b1;
            wait (sensor_pwr_en_pix === 1'b0);
            @(negedge clk72);
            sensor_pgood = 1'b0;
        end
    end

    task automatic host_access(input logic we, input logic [AW-1:0] addr,
                               input logic [DW-1:0] data);
        @(negedge clk72);
        host_addr  = addr;
        host_we    = we;
        host_wdata = data;
        host_valid = 1'b1;
        while (host_ready !== 1'b1) @(negedge clk72);
        // transfer happens on the next rising edge
        @(negedge clk72);
        host_valid = 1'b0;
        if (we) begin
            shadow[addr] = data;
        end else begin
            exp_q.push_back(ref_read(addr));
            reads_issued = reads_issued + 1;
        end
    endtask

    task automatic wait_init_done();
        while (init_done !== 1'b1) @(negedge clk72);
        // edge monitor logs the rise on the next clock
        @(negedge clk72);
    endtask

    task automatic drain_reads();
        while (exp_q.size() != 0) @(negedge clk72);
    endtask

    task automatic check_gap(input string what, input int t_from, input int t_to,
                             input int min_gap);
        checks = checks + 1;
        assert (t_to - t_from >= min_gap) else begin
            $display("%s came %0d cycles after the step before, expected at least %0d",
                     what, t_to - t_from, min_gap);
            errors = errors + 1;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic power_up_order();
        int err0;
        err0 = errors;
        check_gap("vdd33 enable", rise_t[0], rise_t[1], SD);
        check_gap("pix enable", rise_t[1], rise_t[2], SD);
        check_gap("clk_pll after pix", rise_t[2], rise_t[4], SD);
        check_gap("clk_pll after pgood", rise_t[3], rise_t[4], 1);
        check_gap("python_reset_n", rise_t[4], rise_t[5], SD);
        check_gap("init_done", rise_t[5], rise_t[6], 1);
        end_test("power-up order", err0);
    endtask

    task automatic init_table_readback(input string name);
        int err0;
        err0 = errors;
        for (int i = 0; i < spi_pkg::INIT_LEN; i++) begin
            checks = checks + 1;
            assert (u_model.regs[spi_pkg::INIT_ADDR[i]] === spi_pkg::INIT_DATA[i]) else begin
                $display("ERROR model reg %h exp=%h got=%h", spi_pkg::INIT_ADDR[i],
                         spi_pkg::INIT_DATA[i], u_model.regs[spi_pkg::INIT_ADDR[i]]);
                errors = errors + 1;
            end
        end
        for (int i = 0; i < spi_pkg::INIT_LEN; i++) begin
            host_access(1'b0, spi_pkg::INIT_ADDR[i], '0);
        end
        drain_reads();
        end_test(name, err0);
    endtask

    task automatic random_host_rw();
        int            err0;
        logic          we;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            we = ($urandom_range(1, 0) == 1);
            if (we) begin
                addr = AW'($urandom);
                data = DW'($urandom);
                known_q.push_back(addr);
                host_access(1'b1, addr, data);
            end else begin
                addr = known_q[$urandom_range(known_q.size() - 1, 0)];
                host_access(1'b0, addr, '0);
            end
        end
        drain_reads();
        // stray responses would show up within one frame
        repeat (FRAME_CYC) @(negedge clk72);
        checks = checks + 1;
        assert (rvalid_cnt == reads_issued) else begin
            $display("%0d read responses for %0d reads", rvalid_cnt, reads_issued);
            errors = errors + 1;
        end
        end_test("host writes and reads", err0);
    endtask

    task automatic power_down_order();
        int err0;
        err0 = errors;
        @(negedge clk72);
        power_enable = 1'b0;
        while (sensor_pwr_en_vdd18 !== 1'b0) @(negedge clk72);
        // edge monitor logs the fall on the next clock
        @(negedge clk72);
        check_gap("clk_pll off after reset", fall_t[5], fall_t[4], SD);
        check_gap("clk_pll off after init_done", fall_t[6], fall_t[4], 1);
        check_gap("pix off", fall_t[4], fall_t[2], SD);
        check_gap("vdd33 off", fall_t[2], fall_t[1], SD);
        check_gap("vdd18 off", fall_t[1], fall_t[0], SD);
        end_test("power-down order", err0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        void'($urandom(58));
        mipi_reset_n = 1'b0;
        power_enable = 1'b0;
        host_addr    = '0;
        host_we      = 1'b0;
        host_wdata   = '0;
        host_valid   = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        reads_issued = 0;
        rvalid_cnt   = 0;
        frames       = 0;
        bp_errors    = 0;
        sck_edges    = 0;
        cyc          = 0;
        for (int i = 0; i < spi_pkg::INIT_LEN; i++) begin
            known_q.push_back(spi_pkg::INIT_ADDR[i]);
        end
        repeat (16) @(negedge clk72);
        mipi_reset_n = 1'b1;

        load_init_shadow();
        @(negedge clk72);
        power_enable = 1'b1;
        wait_init_done();
        power_up_order();
        init_table_readback("init table");
        random_host_rw();
        power_down_order();

        // second power-up runs the table again
        load_init_shadow();
        @(negedge clk72);
        power_enable = 1'b1;
        wait_init_done();
        init_table_readback("init table after re-enable");

        tests_run = tests_run + 1;
        $display("test back-pressure and framing: %0d frames, %0d errors", frames, bp_errors);
        $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // four times the worst-case power-up plus 40 frames
    initial begin
        #(4 * WORST_CYC * CLK_PERIOD);
        $display("timeout, the run did not finish in %0d cycles", 4 * WORST_CYC);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verification/python_spi_model.sv ====
module python_spi_model (
    input  var logic ss_n,
    input  var logic sck,
    input  var logic mosi,
    output var logic miso
);

    timeunit 1ns;
    timeprecision 1ps;

    // sensor register file
    logic [15:0] regs [0:511];

    logic [25:0] frame;
    logic [15:0] rd_sr;
    logic        is_read;
    int          bit_cnt;

    // reset pattern built from the whole address
    initial begin
        for (int a = 0; a < 512; a++) begin
            regs[a] = {7'h5A, a[8:0]};
        end
        miso    = 1'b0;
        bit_cnt = 0;
        is_read = 1'b0;
    end

    always @(negedge ss_n) begin
        bit_cnt = 0;
    end

    // ----------------------------------------
    // frame decode on sck rising edges
    // ----------------------------------------

    always @(posedge sck) begin
        if (ss_n === 1'b0) begin
            frame   = {frame[24:0], mosi};
            bit_cnt = bit_cnt + 1;
            // address and write bit are in
            if (bit_cnt == 10) begin
                is_read = (frame[0] == 1'b0);
                rd_sr   = regs[frame[9:1]];
            end
            if (bit_cnt == 26 && frame[16] == 1'b1) begin
                regs[frame[25:17]] = frame[15:0];
            end
        end
    end

    // read data goes out MSB first on falling edges
    always @(negedge sck) begin
        if (ss_n === 1'b0 && is_read && bit_cnt >= 10 && bit_cnt < 26) begin
            miso  = rd_sr[15];
            rd_sr = {rd_sr[14:0], 1'b0};
        end
    end

endmodule

// ==== logic/python_ctrl_top.sv ====
module python_ctrl_top (
    input  var logic                        clk72,
    input  var logic                        mipi_reset_n,
    input  var logic                        power_enable,
    input  var logic                        sensor_pgood,

    input  var logic [spi_pkg::ADDR_W-1:0]  host_addr,
    input  var logic                        host_we,
    input  var logic [spi_pkg::DATA_W-1:0]  host_wdata,
    input  var logic                        host_valid,
    output var logic                        host_ready,
    output var logic [spi_pkg::DATA_W-1:0]  host_rdata,
    output var logic                        host_rvalid,
    output var logic                        init_done,

    output var logic                        sensor_pwr_en_vdd18,
    output var logic                        sensor_pwr_en_vdd33,
    output var logic                        sensor_pwr_en_pix,
    output var logic                        python_reset_n,
    output var logic                        python_clk_pll,
    output var logic                        python_ss_n,
    output var logic                        python_sck,
    output var logic                        python_mosi,
    input  var logic                        python_miso
);

    logic sensor_ready;

    spi_req_if host_if ();
    spi_req_if spi_if ();

    // host pins onto the request interface
    assign host_if.addr  = host_addr;
    assign host_if.we    = host_we;
    assign host_if.wdata = host_wdata;
    assign host_if.valid = host_valid;
    assign host_ready    = host_if.ready;
    assign host_rdata    = host_if.rdata;
    assign host_rvalid   = host_if.rvalid;

    sensor_pwr_mng u_sensor_pwr_mng (
        .clk72               (clk72),
        .mipi_reset_n        (mipi_reset_n),
        .enable              (power_enable),
        .sensor_pgood        (sensor_pgood),
        .ready               (sensor_ready),
        .sensor_pwr_en_vdd18 (sensor_pwr_en_vdd18),
        .sensor_pwr_en_vdd33 (sensor_pwr_en_vdd33),
        .sensor_pwr_en_pix   (sensor_pwr_en_pix),
        .python_clk_pll      (python_clk_pll),
        .python_reset_n      (python_reset_n)
    );

    spi_cmd u_spi_cmd (
        .clk72        (clk72),
        .mipi_reset_n (mipi_reset_n),
        .enable       (sensor_ready),
        .host         (host_if.slave),
        .m            (spi_if.master),
        .init_done    (init_done)
    );

    python_spi u_python_spi (
        .clk72        (clk72),
        .mipi_reset_n (mipi_reset_n),
        .s            (spi_if.slave),
        .spi_ss_n     (python_ss_n),
        .spi_sck      (python_sck),
        .spi_mosi     (python_mosi),
        .spi_miso     (python_miso)
    );

endmodule

// ==== logic/spi_cmd.sv ====
module spi_cmd (
    input  var logic  clk72,
    input  var logic  mipi_reset_n,
    input  var logic  enable,
    spi_req_if.slave  host,
    spi_req_if.master m,
    output var logic  init_done
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_INIT,
        C_LAST,
        C_HOST
    } cmd_state_e;

    cmd_state_e                       state;
    logic [spi_pkg::INIT_IDX_W-1:0]   idx;

    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            state     <= C_IDLE;
            idx       <= '0;
            init_done <= 1'b0;
        end else if (!enable) begin
            // sensor gone so the table runs again on the next ready
            state     <= C_IDLE;
            idx       <= '0;
            init_done <= 1'b0;
        end else begin
            unique case (state)
                C_IDLE: begin
                    idx   <= '0;
                    state <= C_INIT;
                end
                C_INIT: begin
                    if (m.valid && m.ready) begin
                        if (idx == spi_pkg::INIT_LAST) begin
                            state <= C_LAST;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                // last init frame still on the wire
                C_LAST: begin
                    if (m.ready) begin
                        init_done <= 1'b1;
                        state     <= C_HOST;
                    end
                end
                C_HOST: begin
                    init_done <= 1'b1;
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // request mux
    // ----------------------------------------

    always_comb begin
        if (state == C_HOST) begin
            m.addr  = host.addr;
            m.we    = host.we;
            m.wdata = host.wdata;
            m.valid = host.valid;
        end else begin
            m.addr  = spi_pkg::INIT_ADDR[idx];
            m.we    = spi_pkg::OP_WRITE;
            m.wdata = spi_pkg::INIT_DATA[idx];
            m.valid = (state == C_INIT);
        end
    end

    // host held off until init is done
    assign host.ready  = init_done && m.ready;
    assign host.rdata  = m.rdata;
    assign host.rvalid = m.rvalid;

endmodule

// ==== python_spi/python_spi.sv ====
module python_spi (
    input  var logic  clk72,
    input  var logic  mipi_reset_n,
    spi_req_if.slave  s,
    output var logic  spi_ss_n,
    output var logic  spi_sck,
    output var logic  spi_mosi,
    input  var logic  spi_miso
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LEAD,
        S_SHIFT,
        S_GAP,
        S_CLOSE,
        S_DONE
    } spi_state_e;

    spi_state_e       state;
    spi_pkg::spi_op_e op;

    logic [spi_pkg::SCK_CNT_W-1:0] div_cnt;
    logic [spi_pkg::BIT_CNT_W-1:0] bit_cnt;
    logic [spi_pkg::FRAME_W-1:0]   tx_sr;
    logic [spi_pkg::DATA_W-1:0]    rx_sr;
    logic [spi_pkg::DATA_W-1:0]    rdata_q;
    logic                          ready_q;
    logic                          rvalid_q;
    logic                          is_read;
    logic                          accept;
    logic                          sck_rise;
    logic                          sck_fall;

    assign op       = s.we ? spi_pkg::OP_WRITE : spi_pkg::OP_READ;
    assign accept   = s.valid && ready_q;
    assign sck_rise = (state == S_SHIFT) && (div_cnt == spi_pkg::SCK_RISE_AT);
    assign sck_fall = (state == S_SHIFT) && (div_cnt == spi_pkg::SCK_FALL_AT);

    assign spi_mosi = tx_sr[spi_pkg::FRAME_W-1];
    assign s.ready  = ready_q;
    assign s.rvalid = rvalid_q;
    assign s.rdata  = rdata_q;

    // ----------------------------------------
    // frame control
    // ----------------------------------------

    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            state    <= S_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            ready_q  <= 1'b0;
            rvalid_q <= 1'b0;
            is_read  <= 1'b0;
            spi_ss_n <= 1'b1;
            spi_sck  <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            unique case (state)
                S_IDLE: begin
                    if (accept) begin
                        ready_q  <= 1'b0;
                        spi_ss_n <= 1'b0;
                        is_read  <= (op == spi_pkg::OP_READ);
                        state    <= S_LEAD;
                    end else begin
                        ready_q <= 1'b1;
                    end
                end
                // one cycle of ss_n setup before the first period
                S_LEAD: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (sck_rise) begin
                        spi_sck <= 1'b1;
                    end
                    if (sck_fall) begin
                        spi_sck <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == spi_pkg::BIT_LAST) begin
                            state <= S_GAP;
                        end
                    end
                end
                S_GAP: begin
                    state <= S_CLOSE;
                end
                S_CLOSE: begin
                    spi_ss_n <= 1'b1;
                    state    <= S_DONE;
                end
                S_DONE: begin
                    ready_q  <= 1'b1;
                    rvalid_q <= is_read;
                    state    <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // shift registers
    // ----------------------------------------

    always_ff @(posedge clk72) begin
        if (accept) begin
            tx_sr <= {s.addr, op, s.wdata};
        end else if (sck_fall) begin
            tx_sr <= {tx_sr[spi_pkg::FRAME_W-2:0], 1'b0};
        end
        // last 16 bits of the frame are the read data
        if (sck_rise) begin
            rx_sr <= {rx_sr[spi_pkg::DATA_W-2:0], spi_miso};
        end
        if (state == S_DONE) begin
            rdata_q <= rx_sr;
        end
    end

endmodule

// ==== sensor_power/sensor_pwr_mng.sv ====
module sensor_pwr_mng (
    input  var logic clk72,
    input  var logic mipi_reset_n,
    input  var logic enable,
    input  var logic sensor_pgood,
    output var logic ready,
    output var logic sensor_pwr_en_vdd18,
    output var logic sensor_pwr_en_vdd33,
    output var logic sensor_pwr_en_pix,
    output var logic python_clk_pll,
    output var logic python_reset_n
);

    sensor_pkg::pwr_state_e state;

    logic [sensor_pkg::STEP_CNT_W-1:0] step_cnt;
    logic                              step_done;
    logic                              timed;
    logic                              pgood_seen;

    assign step_done = (step_cnt == sensor_pkg::STEP_LAST);

    // states that wait a full step delay
    assign timed = (state == sensor_pkg::VDD18) || (state == sensor_pkg::VDD33)
                || (state == sensor_pkg::PIX) || (state == sensor_pkg::CLK_ON)
                || (state == sensor_pkg::RST_REL) || (state == sensor_pkg::DOWN);

    // pgood must hold once the clock is running
    assign pgood_seen = (state == sensor_pkg::CLK_ON) || (state == sensor_pkg::RST_REL)
                     || (state == sensor_pkg::READY);

    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            state               <= sensor_pkg::OFF;
            step_cnt            <= '0;
            ready               <= 1'b0;
            sensor_pwr_en_vdd18 <= 1'b0;
            sensor_pwr_en_vdd33 <= 1'b0;
            sensor_pwr_en_pix   <= 1'b0;
            python_clk_pll      <= 1'b0;
            python_reset_n      <= 1'b0;
        end else begin
            if (!timed || step_done) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            unique case (state)
                sensor_pkg::OFF: begin
                    if (enable) begin
                        sensor_pwr_en_vdd18 <= 1'b1;
                        state               <= sensor_pkg::VDD18;
                    end
                end
                sensor_pkg::VDD18: begin
                    if (step_done) begin
                        sensor_pwr_en_vdd33 <= 1'b1;
                        state               <= sensor_pkg::VDD33;
                    end
                end
                sensor_pkg::VDD33: begin
                    if (step_done) begin
                        sensor_pwr_en_pix <= 1'b1;
                        state             <= sensor_pkg::PIX;
                    end
                end
                sensor_pkg::PIX: begin
                    if (step_done) begin
                        state <= sensor_pkg::PGOOD_WAIT;
                    end
                end
                // no limit on the pgood wait
                sensor_pkg::PGOOD_WAIT: begin
                    if (sensor_pgood) begin
                        python_clk_pll <= 1'b1;
                        state          <= sensor_pkg::CLK_ON;
                    end
                end
                sensor_pkg::CLK_ON: begin
                    if (step_done) begin
                        python_reset_n <= 1'b1;
                        state          <= sensor_pkg::RST_REL;
                    end
                end
                sensor_pkg::RST_REL: begin
                    if (step_done) begin
                        ready <= 1'b1;
                        state <= sensor_pkg::READY;
                    end
                end
                sensor_pkg::READY: begin
                    ready <= 1'b1;
                end
                // one output off per step in reverse power-up order
                sensor_pkg::DOWN: begin
                    if (step_done) begin
                        if (python_clk_pll) begin
                            python_clk_pll <= 1'b0;
                        end else if (sensor_pwr_en_pix) begin
                            sensor_pwr_en_pix <= 1'b0;
                        end else if (sensor_pwr_en_vdd33) begin
                            sensor_pwr_en_vdd33 <= 1'b0;
                        end else begin
                            sensor_pwr_en_vdd18 <= 1'b0;
                            state               <= sensor_pkg::OFF;
                        end
                    end
                end
                default: begin
                    state <= sensor_pkg::OFF;
                end
            endcase

            // disable or lost pgood starts the down sequence
            if ((state != sensor_pkg::OFF) && (state != sensor_pkg::DOWN)
                    && (!enable || (pgood_seen && !sensor_pgood))) begin
                ready          <= 1'b0;
                python_reset_n <= 1'b0;
                step_cnt       <= '0;
                state          <= sensor_pkg::DOWN;
            end
        end
    end

endmodule

// ==== common/spi_req_if.sv ====
interface spi_req_if;

    // request
    logic [spi_pkg::ADDR_W-1:0] addr;
    logic                       we;
    logic [spi_pkg::DATA_W-1:0] wdata;
    logic                       valid;
    logic                       ready;

    // read response
    logic [spi_pkg::DATA_W-1:0] rdata;
    logic                       rvalid;

    modport master (
        output addr, we, wdata, valid,
        input  ready, rdata, rvalid
    );

    modport slave (
        input  addr, we, wdata, valid,
        output ready, rdata, rvalid
    );

endinterface

// ==== common/spi_pkg.sv ====
package spi_pkg;

    // ----------------------------------------
    // PYTHON SPI frame
    // ----------------------------------------

    localparam int ADDR_W  = 9;
    localparam int DATA_W  = 16;
    // address, write bit, data
    localparam int FRAME_W = ADDR_W + 1 + DATA_W;

    // clk72 cycles per SCK period
    localparam int SCK_DIV   = 8;
    localparam int SCK_CNT_W = $clog2(SCK_DIV);
    localparam int BIT_CNT_W = $clog2(FRAME_W);

    // sck edges inside one period
    localparam logic [SCK_CNT_W-1:0] SCK_RISE_AT = SCK_CNT_W'(SCK_DIV / 2 - 1);
    localparam logic [SCK_CNT_W-1:0] SCK_FALL_AT = SCK_CNT_W'(SCK_DIV - 1);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST    = BIT_CNT_W'(FRAME_W - 1);

    // sent as the frame's write bit
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } spi_op_e;

    // ----------------------------------------
    // sensor init table
    // ----------------------------------------

    localparam int INIT_LEN   = 6;
    localparam int INIT_IDX_W = $clog2(INIT_LEN);
    localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'(INIT_LEN - 1);

    // chip config, clock generator and PLL setup
    localparam logic [ADDR_W-1:0] INIT_ADDR [0:INIT_LEN-1] = '{
        9'd2, 9'd32, 9'd20, 9'd17, 9'd26, 9'd27
    };

    localparam logic [DATA_W-1:0] INIT_DATA [0:INIT_LEN-1] = '{
        16'h0000, 16'h2004, 16'h0000, 16'h2113, 16'h2280, 16'h3D2D
    };

endpackage

// ==== common/sensor_pkg.sv ====
package sensor_pkg;

    // ----------------------------------------
    // power sequence
    // ----------------------------------------

    // one state per rail, clock and reset step
    typedef enum logic [3:0] {
        OFF,
        VDD18,
        VDD33,
        PIX,
        PGOOD_WAIT,
        CLK_ON,
        RST_REL,
        READY,
        DOWN
    } pwr_state_e;

    // clk72 cycles between two steps
    localparam int STEP_DELAY = 200;
    localparam int STEP_CNT_W = $clog2(STEP_DELAY);

    // last count of a step delay
    localparam logic [STEP_CNT_W-1:0] STEP_LAST = STEP_CNT_W'(STEP_DELAY - 1);

endpackage
